/* psumPkg.sv */
// ==================================================
// psum buffer package
// operation codes and default sizes shared by the
// receiver, the pipeline stages and the top level
// ==================================================
`default_nettype none

package psumPkg;

    // ==============================================
    // operation carried with each request
    // ==============================================
    typedef enum logic [1:0] {
        // write a value into one stage's bank
        OP_LOAD = 2'd0,
        // run a running sum through all stages
        OP_ACC  = 2'd1,
        // end of frame and flip of the ping-pong pair
        OP_SWAP = 2'd2
    } psumOp_t;

    // ==============================================
    // default sizes
    // ==============================================
    // 16 psums for one 4x4 output map
    localparam int DEF_ADDR_W = 4;

    // signed psum word
    localparam int DEF_PSUM_W = 16;

    // load target index
    // 0 and 1 pick the accumulate stages, 2 the active ping-pong bank
    localparam int SEL_W = 2;

endpackage

`default_nettype wire

/* psumBank.sv */
// ==================================================
// psum SRAM bank
// register array with one write port and one
// registered read port
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module psumBank import psumPkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int PSUM_W = DEF_PSUM_W
) (
    input  logic              clk,
    input  logic              wrEn,
    input  logic [ADDR_W-1:0] wrAddr,
    input  logic [PSUM_W-1:0] wrData,
    input  logic              rdEn,
    input  logic [ADDR_W-1:0] rdAddr,
    output logic [PSUM_W-1:0] rdData
);

    localparam int DEPTH = 1 << ADDR_W;

    // psum storage
    logic [PSUM_W-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read port
    // word shows up the cycle after rdEn
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    // no read from an unknown address
    assert property (@(posedge clk) rdEn |-> !$isunknown(rdAddr))
        else $error("psumBank: read with unknown address");

endmodule

`default_nettype wire

/* reqAckIn.sv */
// ==================================================
// four-phase req/ack receiver
// takes one operation per request and hands it to
// the pipeline as a one-cycle valid
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module reqAckIn import psumPkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int PSUM_W = DEF_PSUM_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  psumOp_t           op,
    input  logic [SEL_W-1:0]  sel,
    input  logic [ADDR_W-1:0] addr,
    input  logic [PSUM_W-1:0] value,
    output logic              ack,
    output logic              inValid,
    output psumOp_t           inOp,
    output logic [SEL_W-1:0]  inSel,
    output logic [ADDR_W-1:0] inAddr,
    output logic [PSUM_W-1:0] inValue
);

    typedef enum logic {IDLE, HOLD} hsState_t;

    hsState_t state;
    logic     accept;

    // new request only while ack is low
    assign accept = (state == IDLE) && req;
    assign ack    = (state == HOLD);

    // ==============================================
    // handshake FSM
    // ==============================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            inValid <= 1'b0;
        end else begin
            inValid <= accept;
            if (accept) begin
                state <= HOLD;
            end else if (state == HOLD && !req) begin
                // req gone, release ack
                state <= IDLE;
            end
        end
    end

    // fields captured once, when the request is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            inOp    <= op;
            inSel   <= sel;
            inAddr  <= addr;
            inValue <= value;
        end
    end

    // ack drops only after req went low
    assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> $past(!req))
        else $error("reqAckIn: ack fell while req still high");

endmodule

`default_nettype wire

/* psumStage.sv */
// ==================================================
// psum accumulate stage
// loads its own bank or adds the stored psum to the
// passing value, two cycles per operation
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module psumStage import psumPkg::*; #(
    parameter int ADDR_W   = DEF_ADDR_W,
    parameter int PSUM_W   = DEF_PSUM_W,
    parameter int STAGE_ID = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inValid,
    input  psumOp_t           inOp,
    input  logic [SEL_W-1:0]  inSel,
    input  logic [ADDR_W-1:0] inAddr,
    input  logic [PSUM_W-1:0] inValue,
    output logic              outValid,
    output psumOp_t           outOp,
    output logic [SEL_W-1:0]  outSel,
    output logic [ADDR_W-1:0] outAddr,
    output logic [PSUM_W-1:0] outValue
);

    // first cycle holds the operation while the bank reads
    logic              p1Valid;
    psumOp_t           p1Op;
    logic [SEL_W-1:0]  p1Sel;
    logic [ADDR_W-1:0] p1Addr;
    logic [PSUM_W-1:0] p1Value;

    logic              bankRdEn;
    logic              bankWrEn;
    logic [PSUM_W-1:0] bankRd;
    logic [PSUM_W-1:0] accSum;

    // only an accumulation needs the stored psum
    assign bankRdEn = inValid && (inOp == OP_ACC);
    // load aimed at this stage
    assign bankWrEn = p1Valid && (p1Op == OP_LOAD) && (p1Sel == SEL_W'(STAGE_ID));
    // signed add, wraps at PSUM_W
    assign accSum   = $signed(p1Value) + $signed(bankRd);

    psumBank #(
        .ADDR_W (ADDR_W),
        .PSUM_W (PSUM_W)
    ) bank_inst (
        .clk    (clk),
        .wrEn   (bankWrEn),
        .wrAddr (p1Addr),
        .wrData (p1Value),
        .rdEn   (bankRdEn),
        .rdAddr (inAddr),
        .rdData (bankRd)
    );

    // ==============================================
    // valid chain
    // ==============================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1Valid  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            p1Valid  <= inValid;
            outValid <= p1Valid;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        p1Op     <= inOp;
        p1Sel    <= inSel;
        p1Addr   <= inAddr;
        p1Value  <= inValue;
        outOp    <= p1Op;
        outSel   <= p1Sel;
        outAddr  <= p1Addr;
        // everything but an accumulation passes untouched
        outValue <= (p1Op == OP_ACC) ? accSum : p1Value;
    end

    // upstream pacing leaves a gap between operations
    assert property (@(posedge clk) disable iff (!rst_n) inValid |=> !inValid)
        else $error("psumStage %0d: back-to-back valid", STAGE_ID);

endmodule

`default_nettype wire

/* pingPongStage.sv */
// ==================================================
// ping-pong psum stage
// writes finished sums into the active bank while
// pooling reads the other one; swap flips the pair
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module pingPongStage import psumPkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int PSUM_W = DEF_PSUM_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inValid,
    input  psumOp_t           inOp,
    input  logic [SEL_W-1:0]  inSel,
    input  logic [ADDR_W-1:0] inAddr,
    input  logic [PSUM_W-1:0] inValue,
    input  logic              poolEnRd,
    input  logic [ADDR_W-1:0] poolAddr,
    output logic [PSUM_W-1:0] poolData,
    output logic              poolStart
);

    // load target of the active bank
    localparam logic [SEL_W-1:0] PP_SEL = SEL_W'(2);

    logic              p1Valid;
    psumOp_t           p1Op;
    logic [SEL_W-1:0]  p1Sel;
    logic [ADDR_W-1:0] p1Addr;
    logic [PSUM_W-1:0] p1Value;

    // 0 means bank A takes writes
    logic              activeB;
    logic              swapSeen;
    logic              rdFromB;
    logic              wrReq;
    logic              isSwap;
    logic              wrEnA;
    logic              wrEnB;
    logic              rdEnA;
    logic              rdEnB;
    logic [PSUM_W-1:0] rdDataA;
    logic [PSUM_W-1:0] rdDataB;

    // finished sum or direct load
    assign wrReq  = p1Valid && ((p1Op == OP_ACC) || (p1Op == OP_LOAD && p1Sel == PP_SEL));
    assign isSwap = p1Valid && (p1Op == OP_SWAP);

    // writes to active bank, pool reads from the other
    assign wrEnA = wrReq && !activeB;
    assign wrEnB = wrReq && activeB;
    assign rdEnA = poolEnRd && activeB;
    assign rdEnB = poolEnRd && !activeB;

    assign poolData = rdFromB ? rdDataB : rdDataA;

    psumBank #(
        .ADDR_W (ADDR_W),
        .PSUM_W (PSUM_W)
    ) bankA_inst (
        .clk    (clk),
        .wrEn   (wrEnA),
        .wrAddr (p1Addr),
        .wrData (p1Value),
        .rdEn   (rdEnA),
        .rdAddr (poolAddr),
        .rdData (rdDataA)
    );

    psumBank #(
        .ADDR_W (ADDR_W),
        .PSUM_W (PSUM_W)
    ) bankB_inst (
        .clk    (clk),
        .wrEn   (wrEnB),
        .wrAddr (p1Addr),
        .wrData (p1Value),
        .rdEn   (rdEnB),
        .rdAddr (poolAddr),
        .rdData (rdDataB)
    );

    // ==============================================
    // bank select and pool start
    // ==============================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1Valid   <= 1'b0;
            activeB   <= 1'b0;
            swapSeen  <= 1'b0;
            poolStart <= 1'b0;
            rdFromB   <= 1'b0;
        end else begin
            p1Valid   <= inValid;
            // first frame is never pooled
            poolStart <= isSwap && swapSeen;
            if (isSwap) begin
                activeB  <= !activeB;
                swapSeen <= 1'b1;
            end
            // remember which bank the pending pool read hit
            if (poolEnRd) begin
                rdFromB <= !activeB;
            end
        end
    end

    always_ff @(posedge clk) begin
        p1Op    <= inOp;
        p1Sel   <= inSel;
        p1Addr  <= inAddr;
        p1Value <= inValue;
    end

endmodule

`default_nettype wire

/* psumBlock.sv */
// ==================================================
// psum buffer block
// four-phase input, two accumulate stages and the
// ping-pong stage feeding the pooling unit
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module psumBlock import psumPkg::*; #(
    parameter int ADDR_W = DEF_ADDR_W,
    parameter int PSUM_W = DEF_PSUM_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  psumOp_t           op,
    input  logic [SEL_W-1:0]  sel,
    input  logic [ADDR_W-1:0] addr,
    input  logic [PSUM_W-1:0] value,
    input  logic              poolEnRd,
    input  logic [ADDR_W-1:0] poolAddr,
    output logic              ack,
    output logic [PSUM_W-1:0] poolData,
    output logic              poolStart
);

    // receiver to stage 0
    logic              rxValid;
    psumOp_t           rxOp;
    logic [SEL_W-1:0]  rxSel;
    logic [ADDR_W-1:0] rxAddr;
    logic [PSUM_W-1:0] rxValue;

    // stage 0 to stage 1
    logic              s0Valid;
    psumOp_t           s0Op;
    logic [SEL_W-1:0]  s0Sel;
    logic [ADDR_W-1:0] s0Addr;
    logic [PSUM_W-1:0] s0Value;

    // stage 1 to ping-pong
    logic              s1Valid;
    psumOp_t           s1Op;
    logic [SEL_W-1:0]  s1Sel;
    logic [ADDR_W-1:0] s1Addr;
    logic [PSUM_W-1:0] s1Value;

    reqAckIn #(
        .ADDR_W (ADDR_W),
        .PSUM_W (PSUM_W)
    ) reqAckIn_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .op      (op),
        .sel     (sel),
        .addr    (addr),
        .value   (value),
        .ack     (ack),
        .inValid (rxValid),
        .inOp    (rxOp),
        .inSel   (rxSel),
        .inAddr  (rxAddr),
        .inValue (rxValue)
    );

    psumStage #(
        .ADDR_W   (ADDR_W),
        .PSUM_W   (PSUM_W),
        .STAGE_ID (0)
    ) stage0_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (rxValid),
        .inOp     (rxOp),
        .inSel    (rxSel),
        .inAddr   (rxAddr),
        .inValue  (rxValue),
        .outValid (s0Valid),
        .outOp    (s0Op),
        .outSel   (s0Sel),
        .outAddr  (s0Addr),
        .outValue (s0Value)
    );

    psumStage #(
        .ADDR_W   (ADDR_W),
        .PSUM_W   (PSUM_W),
        .STAGE_ID (1)
    ) stage1_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (s0Valid),
        .inOp     (s0Op),
        .inSel    (s0Sel),
        .inAddr   (s0Addr),
        .inValue  (s0Value),
        .outValid (s1Valid),
        .outOp    (s1Op),
        .outSel   (s1Sel),
        .outAddr  (s1Addr),
        .outValue (s1Value)
    );

    pingPongStage #(
        .ADDR_W (ADDR_W),
        .PSUM_W (PSUM_W)
    ) pingPong_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .inValid   (s1Valid),
        .inOp      (s1Op),
        .inSel     (s1Sel),
        .inAddr    (s1Addr),
        .inValue   (s1Value),
        .poolEnRd  (poolEnRd),
        .poolAddr  (poolAddr),
        .poolData  (poolData),
        .poolStart (poolStart)
    );

endmodule

`default_nettype wire

/* psumChecker.sv */
// ==================================================
// psum block checker
// watches the DUT ports, compares pool reads and
// pool-start counts, checks the four-phase handshake
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module psumChecker #(
    parameter int PSUM_W = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  logic              ack,
    input  logic              poolEnRd,
    input  logic [PSUM_W-1:0] poolData,
    input  logic              poolStart,
    input  logic [127:0]      testName,
    input  logic [PSUM_W-1:0] expData,
    input  logic              cntCheck,
    input  int                expCount,
    output int                testCount,
    output int                errCount
);

    // pool read waiting for its data
    logic              rdPending;
    logic [127:0]      rdName;
    logic [PSUM_W-1:0] rdExp;

    // handshake history
    logic              prevReq;
    logic              prevAck;
    logic              reqArmed;
    int                pulseCount;

    initial begin
        testCount  = 0;
        errCount   = 0;
        pulseCount = 0;
        rdPending  = 1'b0;
        prevReq    = 1'b0;
        prevAck    = 1'b0;
        reqArmed   = 1'b0;
    end

    // ==============================================
    // pool reads and pulse counts
    // ==============================================
    always @(posedge clk) begin
        // data registered one cycle after poolEnRd
        if (rdPending) begin
            testCount++;
            if (poolData !== rdExp) begin
                errCount++;
                $display("ERR %0s expected %h actual %h", rdName, rdExp, poolData);
            end else begin
                $display("ok  %0s read %h", rdName, poolData);
            end
        end
        rdPending = poolEnRd;
        if (poolEnRd) begin
            rdName = testName;
            rdExp  = expData;
        end
        // count check before this cycle's pulse
        if (cntCheck) begin
            testCount++;
            if (pulseCount != expCount) begin
                errCount++;
                $display("ERR %0s expected %0d actual %0d", testName, expCount, pulseCount);
            end else begin
                $display("ok  %0s pulses %0d", testName, pulseCount);
            end
        end
        if (poolStart) begin
            pulseCount++;
        end
    end

    // ==============================================
    // four-phase handshake
    // ==============================================
    always @(posedge clk) begin
        if (!rst_n) begin
            if (ack) begin
                errCount++;
                $display("handshake error: ack is high during reset");
            end
        end else begin
            // a fresh request allows one ack rise
            if (req && !prevReq) begin
                reqArmed = 1'b1;
            end
            if (ack && !prevAck) begin
                if (!prevReq) begin
                    errCount++;
                    $display("handshake error: ack rose while req was low");
                end else if (!reqArmed) begin
                    errCount++;
                    $display("handshake error: ack rose twice for one request");
                end
                reqArmed = 1'b0;
            end
        end
        prevReq = req;
        prevAck = ack;
    end

endmodule

`default_nettype wire

/* psumBlock_tb.sv */
// ==================================================
// psum block testbench
// reads commands from the data file and drives the
// four-phase port and the pool read port
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module psumBlock_tb
    import psumPkg::*;
();

    localparam int ADDR_W = DEF_ADDR_W;
    localparam int PSUM_W = DEF_PSUM_W;

    logic              clk;
    logic              rst_n;
    logic              req;
    psumOp_t           op;
    logic [SEL_W-1:0]  sel;
    logic [ADDR_W-1:0] addr;
    logic [PSUM_W-1:0] value;
    logic              poolEnRd;
    logic [ADDR_W-1:0] poolAddr;
    logic              ack;
    logic [PSUM_W-1:0] poolData;
    logic              poolStart;

    // checker side
    logic [127:0]      testName;
    logic [PSUM_W-1:0] expData;
    logic              cntCheck;
    int                expCount;
    int                testCount;
    int                errCount;

    // parsed commands, one entry per data line
    logic [7:0]        cmdQ[$];
    int                argA[$];
    int                argB[$];
    int                argC[$];
    logic [127:0]      nameQ[$];

    int                lineCount;
    int                cycleCount;
    int                cycleLimit = 200;
    int                swapCount;
    bit                fileOk;

    psumBlock #(
        .ADDR_W (ADDR_W),
        .PSUM_W (PSUM_W)
    ) psumBlock_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op        (op),
        .sel       (sel),
        .addr      (addr),
        .value     (value),
        .poolEnRd  (poolEnRd),
        .poolAddr  (poolAddr),
        .ack       (ack),
        .poolData  (poolData),
        .poolStart (poolStart)
    );

    psumChecker #(
        .PSUM_W (PSUM_W)
    ) checker_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .poolEnRd  (poolEnRd),
        .poolData  (poolData),
        .poolStart (poolStart),
        .testName  (testName),
        .expData   (expData),
        .cntCheck  (cntCheck),
        .expCount  (expCount),
        .testCount (testCount),
        .errCount  (errCount)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================================
    // data file parsing
    // ==============================================
    task automatic loadCommands(output bit ok);
        int           fd;
        int           n;
        int           a;
        int           b;
        int           c;
        logic [127:0] tok;
        logic [127:0] nm;
        logic [959:0] skip;
        ok = 1'b0;
        fd = $fopen("psumBlock_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open psumBlock_testdata.txt");
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                tok = '0;
                nm  = '0;
                a   = 0;
                b   = 0;
                c   = 0;
                n   = $fscanf(fd, "%s", tok);
                if (n == 1) begin
                    lineCount++;
                    if (tok == "#") begin
                        // rest of a comment line
                        n = $fgets(skip, fd);
                    end else begin
                        if (tok == "L") begin
                            n = $fscanf(fd, "%d %h %h", a, b, c);
                            ok &= (n == 3);
                        end else if (tok == "A") begin
                            n = $fscanf(fd, "%h %h", a, b);
                            ok &= (n == 2);
                        end else if (tok == "R") begin
                            n = $fscanf(fd, "%s %h %h", nm, a, b);
                            ok &= (n == 3);
                        end else if (tok == "P") begin
                            n = $fscanf(fd, "%s %d", nm, a);
                            ok &= (n == 2);
                        end else if (tok != "S") begin
                            ok = 1'b0;
                        end
                        cmdQ.push_back(tok[7:0]);
                        argA.push_back(a);
                        argB.push_back(b);
                        argC.push_back(c);
                        nameQ.push_back(nm);
                    end
                end
            end
            $fclose(fd);
            if (!ok) begin
                $display("test data file has a malformed line");
            end
        end
        // 40 cycles per data line plus a margin
        cycleLimit = 40 * lineCount + 200;
    endtask

    // ==============================================
    // drivers, all on the falling edge
    // ==============================================
    task automatic sendOp(input psumOp_t o, input int s, input int a, input int v);
        op    = o;
        sel   = SEL_W'(s);
        addr  = ADDR_W'(a);
        value = PSUM_W'(v);
        req   = 1'b1;
        do @(negedge clk); while (!ack);
        req = 1'b0;
        do @(negedge clk); while (ack);
        // keep operations apart in the pipeline
        repeat (2) @(negedge clk);
    endtask

    task automatic poolRead(input logic [127:0] name, input int a, input int e);
        testName = name;
        expData  = PSUM_W'(e);
        poolAddr = ADDR_W'(a);
        poolEnRd = 1'b1;
        @(negedge clk);
        poolEnRd = 1'b0;
    endtask

    task automatic pulseCheck(input logic [127:0] name, input int cnt);
        testName = name;
        expCount = cnt;
        cntCheck = 1'b1;
        @(negedge clk);
        cntCheck = 1'b0;
    endtask

    // swap done once pool-start shows up
    task automatic waitPoolStart();
        while (!poolStart) @(negedge clk);
        @(negedge clk);
    endtask

    // cycle limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ==============================================
    // main sequence
    // ==============================================
    initial begin
        rst_n      = 1'b0;
        req        = 1'b0;
        op         = OP_LOAD;
        sel        = '0;
        addr       = '0;
        value      = '0;
        poolEnRd   = 1'b0;
        poolAddr   = '0;
        testName   = '0;
        expData    = '0;
        cntCheck   = 1'b0;
        expCount   = 0;
        lineCount  = 0;
        cycleCount = 0;
        swapCount  = 0;
        loadCommands(fileOk);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        if (fileOk) begin
            for (int i = 0; i < cmdQ.size(); i++) begin
                case (cmdQ[i])
                    "L": sendOp(OP_LOAD, argA[i], argB[i], argC[i]);
                    "A": sendOp(OP_ACC, 0, argA[i], argB[i]);
                    "S": begin
                        sendOp(OP_SWAP, 0, 0, 0);
                        swapCount++;
                        // first frame is never pooled
                        if (swapCount > 1) begin
                            waitPoolStart();
                        end
                    end
                    "R": poolRead(nameQ[i], argA[i], argB[i]);
                    default: pulseCheck(nameQ[i], argA[i]);
                endcase
            end
        end
        // last compare lands a cycle later
        repeat (4) @(negedge clk);
        $display("tests run %0d, errors %0d", testCount, errCount);
        if (fileOk && errCount == 0 && testCount > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* psumBlock.f */
psumPkg.sv
psumBank.sv
reqAckIn.sv
psumStage.sv
pingPongStage.sv
psumBlock.sv
psumChecker.sv
psumBlock_tb.sv

/* psumBlock_testdata.txt */
# L sel addr value | A addr value | S | R name addr expected | P name pulseCount
# addr, value and expected in hex; sel and pulseCount in decimal
L 0 1 0011
L 1 1 0022
L 2 1 0033
S
L 2 1 0044
S
P swapTwo 1
R directLoad 1 0044
L 0 2 0100
L 1 2 0020
A 2 0003
A 1 0005
L 0 4 7ff0
L 1 4 0020
A 4 0001
S
P swapThree 2
R accSum 2 0123
R accChain 1 0038
R accWrap 4 8011
A 2 1000
R isolation 2 0123
S
P swapFour 3
R newSum 2 1120
R keptLoad 1 0044
